// ==== fe_pkg.sv ====
package fe_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // address and instruction widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int vaddr_width_c       = 32;
   localparam int page_offset_width_c = 12;
   localparam int vtag_width_c        = 20;
   localparam int ptag_width_c        = 20;
   localparam int instr_width_c       = 32;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // cache line geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int line_words_c        = 4;
   localparam int byte_offset_width_c = $clog2(instr_width_c / 8);
   localparam int word_offset_width_c = $clog2(line_words_c);
   localparam int line_offset_width_c = byte_offset_width_c + word_offset_width_c;

   // pages whose ptag has this bit set are uncached I/O
   localparam int pma_io_bit_c = 19;

   typedef enum logic [1:0] {
      fe_op_fetch     = 2'd0,
      fe_op_tlb_fill  = 2'd1,
      fe_op_tlb_fence = 2'd2
   } fe_op_e;

   typedef enum logic [1:0] {
      priv_u = 2'd0,
      priv_s = 2'd1
   } priv_e;

endpackage

// ==== fe_itlb.sv ====
`timescale 1ns/1ns

module fe_itlb
   import fe_pkg::*;
#(
   parameter int itlb_els_p = 8
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    flush_i,
   input  logic                    translation_en_i,
   input  logic                    lookup_v_i,
   input  logic                    fill_v_i,
   input  logic [vtag_width_c-1:0] vtag_i,
   input  logic [ptag_width_c-1:0] fill_ptag_i,
   input  logic                    fill_u_i,
   input  logic                    fill_x_i,
   output logic                    hit_v_o,
   output logic                    miss_v_o,
   output logic [ptag_width_c-1:0] ptag_o,
   output logic                    u_o,
   output logic                    x_o
);

   localparam int ptr_width_lp = (itlb_els_p > 1) ? $clog2(itlb_els_p) : 1;

   logic [itlb_els_p-1:0]   valid_r;
   logic [vtag_width_c-1:0] vtag_r [itlb_els_p];
   logic [ptag_width_c-1:0] ptag_r [itlb_els_p];
   logic [itlb_els_p-1:0]   u_r;
   logic [itlb_els_p-1:0]   x_r;
   logic [itlb_els_p-1:0]   match;
   logic                    any_match;
   logic [ptr_width_lp-1:0] match_idx;
   logic [ptr_width_lp-1:0] rr_ptr_r;

   always_comb begin
      match_idx = '0;
      for (int i = 0; i < itlb_els_p; i++) begin
         match[i] = valid_r[i] && (vtag_r[i] == vtag_i);
         if (match[i]) begin
            match_idx = ptr_width_lp'(i);
         end
      end
   end

   assign any_match = |match;

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         vtag_r[rr_ptr_r] <= vtag_i;
         ptag_r[rr_ptr_r] <= fill_ptag_i;
         u_r[rr_ptr_r]    <= fill_u_i;
         x_r[rr_ptr_r]    <= fill_x_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r  <= '0;
         rr_ptr_r <= '0;
      end else if (flush_i) begin
         valid_r <= '0;
      end else if (fill_v_i) begin
         valid_r[rr_ptr_r] <= 1'b1;
         rr_ptr_r <= (rr_ptr_r == ptr_width_lp'(itlb_els_p - 1)) ? '0 : rr_ptr_r + 1'b1;
      end
   end

   // translation off passes the vtag through as an executable user page
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         hit_v_o  <= 1'b0;
         miss_v_o <= 1'b0;
      end else begin
         hit_v_o  <= lookup_v_i && (!translation_en_i || any_match);
         miss_v_o <= lookup_v_i && translation_en_i && !any_match;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_v_i) begin
         ptag_o <= translation_en_i ? ptag_r[match_idx] : vtag_i;
         u_o    <= !translation_en_i || u_r[match_idx];
         x_o    <= !translation_en_i || x_r[match_idx];
      end
   end

   a_single_match: assert property (@(posedge clk_i) disable iff (reset_i)
      lookup_v_i |-> $onehot0(match));

endmodule

// ==== fe_icache.sv ====
`timescale 1ns/1ns

module fe_icache
   import fe_pkg::*;
#(
   parameter int icache_sets_p = 64
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     fetch_v_i,
   input  logic [vaddr_width_c-1:0] vaddr_i,
   input  logic [ptag_width_c-1:0]  ptag_i,
   input  logic                     ptag_v_i,
   input  logic                     uncached_i,
   input  logic                     kill_i,
   input  logic                     refill_we_i,
   input  logic [instr_width_c-1:0] refill_word_i,
   input  logic [$clog2(icache_sets_p)+word_offset_width_c-1:0] refill_idx_i,
   input  logic                     refill_done_i,
   input  logic                     unc_we_i,
   input  logic [instr_width_c-1:0] unc_data_i,
   output logic                     ready_o,
   output logic                     data_v_o,
   output logic [instr_width_c-1:0] data_o,
   output logic                     refill_req_o,
   output logic                     uncached_req_o,
   output logic [vaddr_width_c-1:0] miss_paddr_o
);

   localparam int set_width_lp = $clog2(icache_sets_p);
   localparam int idx_width_lp = set_width_lp + word_offset_width_c;

   logic [instr_width_c-1:0] data_mem [icache_sets_p*line_words_c];
   logic [ptag_width_c-1:0]  tag_mem [icache_sets_p];
   logic [icache_sets_p-1:0] valid_r;

   logic [set_width_lp-1:0]        rd_set;
   logic [idx_width_lp-1:0]        rd_idx;
   logic                           fetch_v_r;
   logic [page_offset_width_c-1:0] offset_r;
   logic [instr_width_c-1:0]       rd_data_r;
   logic [ptag_width_c-1:0]        rd_tag_r;
   logic                           rd_valid_r;
   logic [set_width_lp-1:0]        fetch_set;
   logic [set_width_lp-1:0]        miss_set;

   logic                                       busy_r;
   logic                                       miss_unc_r;
   logic                                       unc_v_r;
   logic [vaddr_width_c-1:byte_offset_width_c] unc_addr_r;
   logic [instr_width_c-1:0]                   unc_data_r;
   logic                                       unc_hit;
   logic                                       cache_hit;
   logic                                       hit;
   logic                                       miss;

   // the set index lies inside the page offset, so the virtual index is safe
   assign rd_set    = vaddr_i[line_offset_width_c +: set_width_lp];
   assign rd_idx    = vaddr_i[byte_offset_width_c +: idx_width_lp];
   assign fetch_set = offset_r[line_offset_width_c +: set_width_lp];
   assign miss_set  = miss_paddr_o[line_offset_width_c +: set_width_lp];

   always_ff @(posedge clk_i) begin
      rd_data_r  <= data_mem[rd_idx];
      rd_tag_r   <= tag_mem[rd_set];
      rd_valid_r <= valid_r[rd_set];
      offset_r   <= vaddr_i[page_offset_width_c-1:0];
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tag compare at T+1
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign unc_hit   = unc_v_r &&
                      (unc_addr_r == {ptag_i, offset_r[page_offset_width_c-1:byte_offset_width_c]});
   assign cache_hit = rd_valid_r && (rd_tag_r == ptag_i);
   assign hit       = fetch_v_r && ptag_v_i && (uncached_i ? unc_hit : cache_hit);
   assign miss      = fetch_v_r && !hit && !kill_i;
   assign ready_o   = !busy_r;

   always_ff @(posedge clk_i) begin
      data_o <= uncached_i ? unc_data_r : rd_data_r;
      if (refill_we_i) begin
         data_mem[refill_idx_i] <= refill_word_i;
      end
      if (miss && !busy_r) begin
         miss_paddr_o <= {ptag_i, offset_r};
         miss_unc_r   <= uncached_i;
         if (!uncached_i) begin
            tag_mem[fetch_set] <= ptag_i;
         end
      end
      if (unc_we_i) begin
         unc_addr_r <= miss_paddr_o[vaddr_width_c-1:byte_offset_width_c];
         unc_data_r <= unc_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r      <= 1'b0;
         data_v_o       <= 1'b0;
         busy_r         <= 1'b0;
         refill_req_o   <= 1'b0;
         uncached_req_o <= 1'b0;
         valid_r        <= '0;
         unc_v_r        <= 1'b0;
      end else begin
         fetch_v_r      <= fetch_v_i;
         data_v_o       <= hit;
         refill_req_o   <= 1'b0;
         uncached_req_o <= 1'b0;
         if (miss && !busy_r) begin
            busy_r         <= 1'b1;
            refill_req_o   <= !uncached_i;
            uncached_req_o <= uncached_i;
            // the line stays invalid while its words are being replaced
            if (!uncached_i) begin
               valid_r[fetch_set] <= 1'b0;
            end
         end else if (refill_done_i) begin
            busy_r <= 1'b0;
            if (!miss_unc_r) begin
               valid_r[miss_set] <= 1'b1;
            end
         end
         if (unc_we_i) begin
            unc_v_r <= 1'b1;
         end
      end
   end

   a_no_fetch_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      fetch_v_i |-> ready_o);

endmodule

// ==== fe_refill.sv ====
`timescale 1ns/1ns

module fe_refill
   import fe_pkg::*;
#(
   parameter int icache_sets_p = 64
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     req_i,
   input  logic [vaddr_width_c-1:0] paddr_i,
   input  logic                     wb_ack_i,
   input  logic [instr_width_c-1:0] wb_dat_i,
   output logic [vaddr_width_c-1:0] wb_adr_o,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o,
   output logic                     we_o,
   output logic [instr_width_c-1:0] word_o,
   output logic [$clog2(icache_sets_p)+word_offset_width_c-1:0] idx_o,
   output logic                     done_o
);

   localparam int set_width_lp = $clog2(icache_sets_p);

   logic [vaddr_width_c-1:line_offset_width_c] line_r;
   logic [word_offset_width_c-1:0]             cnt_r;
   logic                                       last;

   assign last     = (cnt_r == word_offset_width_c'(line_words_c - 1));
   assign wb_adr_o = {line_r, cnt_r, {byte_offset_width_c{1'b0}}};
   assign we_o     = wb_stb_o && wb_ack_i;
   assign word_o   = wb_dat_i;
   assign idx_o    = {line_r[line_offset_width_c +: set_width_lp], cnt_r};

   always_ff @(posedge clk_i) begin
      if (!wb_cyc_o && req_i) begin
         line_r <= paddr_i[vaddr_width_c-1:line_offset_width_c];
      end
   end

   // cyc stays up for the whole line, stb drops for a cycle after each ack
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wb_cyc_o <= 1'b0;
         wb_stb_o <= 1'b0;
         cnt_r    <= '0;
         done_o   <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (!wb_cyc_o) begin
            if (req_i) begin
               wb_cyc_o <= 1'b1;
               wb_stb_o <= 1'b1;
               cnt_r    <= '0;
            end
         end else if (we_o) begin
            wb_stb_o <= 1'b0;
            if (last) begin
               wb_cyc_o <= 1'b0;
               done_o   <= 1'b1;
            end else begin
               cnt_r <= cnt_r + 1'b1;
            end
         end else if (!wb_stb_o) begin
            wb_stb_o <= 1'b1;
         end
      end
   end

endmodule

// ==== fe_uncached.sv ====
`timescale 1ns/1ns

module fe_uncached
   import fe_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     req_i,
   input  logic [vaddr_width_c-1:0] paddr_i,
   input  logic                     wb_ack_i,
   input  logic [instr_width_c-1:0] wb_dat_i,
   output logic [vaddr_width_c-1:0] wb_adr_o,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o,
   output logic                     we_o,
   output logic [instr_width_c-1:0] data_o,
   output logic                     done_o
);

   logic [vaddr_width_c-1:byte_offset_width_c] word_addr_r;

   assign wb_adr_o = {word_addr_r, {byte_offset_width_c{1'b0}}};
   assign we_o     = wb_stb_o && wb_ack_i;
   assign data_o   = wb_dat_i;

   always_ff @(posedge clk_i) begin
      if (!wb_cyc_o && req_i) begin
         word_addr_r <= paddr_i[vaddr_width_c-1:byte_offset_width_c];
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wb_cyc_o <= 1'b0;
         wb_stb_o <= 1'b0;
         done_o   <= 1'b0;
      end else begin
         done_o <= we_o;
         if (!wb_cyc_o && req_i) begin
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
         end else if (we_o) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
         end
      end
   end

endmodule

// ==== fe_wb_arbiter.sv ====
`timescale 1ns/1ns

module fe_wb_arbiter
   import fe_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     m0_cyc_i,
   input  logic                     m0_stb_i,
   input  logic [vaddr_width_c-1:0] m0_adr_i,
   input  logic                     m1_cyc_i,
   input  logic                     m1_stb_i,
   input  logic [vaddr_width_c-1:0] m1_adr_i,
   input  logic                     wb_ack_i,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o,
   output logic [vaddr_width_c-1:0] wb_adr_o,
   output logic                     ack0_o,
   output logic                     ack1_o
);

   logic grant_v_r;
   logic grant_r;
   logic sel_cyc;

   assign sel_cyc = grant_r ? m1_cyc_i : m0_cyc_i;

   // master 0 wins a tie, and a grant is held until its cyc falls
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         grant_v_r <= 1'b0;
         grant_r   <= 1'b0;
      end else if (!grant_v_r) begin
         if (m0_cyc_i) begin
            grant_v_r <= 1'b1;
            grant_r   <= 1'b0;
         end else if (m1_cyc_i) begin
            grant_v_r <= 1'b1;
            grant_r   <= 1'b1;
         end
      end else if (!sel_cyc) begin
         grant_v_r <= 1'b0;
      end
   end

   assign wb_cyc_o = grant_v_r && sel_cyc;
   assign wb_stb_o = grant_v_r && (grant_r ? m1_stb_i : m0_stb_i);
   assign wb_adr_o = grant_r ? m1_adr_i : m0_adr_i;
   assign ack0_o   = grant_v_r && !grant_r && wb_ack_i;
   assign ack1_o   = grant_v_r && grant_r && wb_ack_i;

   // every ack from the slave reaches exactly one master
   a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_ack_i |-> (ack0_o ^ ack1_o));

endmodule

// ==== fe_mem.sv ====
`timescale 1ns/1ns

module fe_mem
   import fe_pkg::*;
#(
   parameter int itlb_els_p    = 8,
   parameter int icache_sets_p = 64
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     mem_cmd_v_i,
   input  fe_op_e                   mem_cmd_op_i,
   input  logic [vaddr_width_c-1:0] mem_cmd_vaddr_i,
   input  logic [ptag_width_c-1:0]  mem_cmd_ptag_i,
   input  logic                     mem_cmd_u_i,
   input  logic                     mem_cmd_x_i,
   input  priv_e                    mem_priv_i,
   input  logic                     mem_translation_en_i,
   input  logic                     mem_poison_i,
   input  logic                     uncached_mode_i,
   input  logic                     wb_ack_i,
   input  logic [instr_width_c-1:0] wb_dat_i,
   output logic                     mem_cmd_yumi_o,
   output logic                     mem_resp_v_o,
   output logic [instr_width_c-1:0] mem_resp_data_o,
   output logic                     mem_resp_itlb_miss_o,
   output logic                     mem_resp_page_fault_o,
   output logic                     mem_resp_access_fault_o,
   output logic                     mem_resp_icache_miss_o,
   output logic [vaddr_width_c-1:0] wb_adr_o,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o
);

   localparam int refill_idx_width_lp = $clog2(icache_sets_p) + word_offset_width_c;

   logic fetch_v, fill_v, fence_v;
   logic itlb_hit, itlb_miss, itlb_u, itlb_x;
   logic [ptag_width_c-1:0] itlb_ptag;
   logic uncached, page_fault, access_fault, kill;
   logic icache_ready, icache_data_v, refill_req, uncached_req;
   logic [vaddr_width_c-1:0] miss_paddr;
   logic refill_we, refill_done, unc_we, unc_done;
   logic [instr_width_c-1:0] refill_word;
   logic [instr_width_c-1:0] unc_data;
   logic [refill_idx_width_lp-1:0] refill_idx;
   logic [vaddr_width_c-1:0] m0_adr, m1_adr;
   logic m0_cyc, m0_stb, m1_cyc, m1_stb, ack0, ack1;
   logic fetch_v_r, fetch_v_rr, itlb_miss_r, page_fault_r, access_fault_r;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // command decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign fence_v = mem_cmd_v_i && (mem_cmd_op_i == fe_op_tlb_fence);
   assign fill_v  = mem_cmd_v_i && (mem_cmd_op_i == fe_op_tlb_fill);
   assign fetch_v = mem_cmd_v_i && (mem_cmd_op_i == fe_op_fetch) && icache_ready;
   assign mem_cmd_yumi_o = fence_v || fill_v || fetch_v;

   fe_itlb #(.itlb_els_p(itlb_els_p)) i_itlb (
      .clk_i, .reset_i, .flush_i(fence_v), .translation_en_i(mem_translation_en_i),
      .lookup_v_i(fetch_v), .fill_v_i(fill_v),
      .vtag_i(mem_cmd_vaddr_i[vaddr_width_c-1:page_offset_width_c]),
      .fill_ptag_i(mem_cmd_ptag_i), .fill_u_i(mem_cmd_u_i), .fill_x_i(mem_cmd_x_i),
      .hit_v_o(itlb_hit), .miss_v_o(itlb_miss), .ptag_o(itlb_ptag), .u_o(itlb_u), .x_o(itlb_x)
   );

   // faults are judged at T+1 against the registered ITLB entry
   assign uncached     = itlb_ptag[pma_io_bit_c];
   assign page_fault   = fetch_v_r && itlb_hit && mem_translation_en_i &&
                         (((mem_priv_i == priv_s) && itlb_u) ||
                          ((mem_priv_i == priv_u) && !itlb_u) || !itlb_x);
   assign access_fault = fetch_v_r && uncached_mode_i && !uncached;
   assign kill         = mem_poison_i || itlb_miss || page_fault || access_fault;

   fe_icache #(.icache_sets_p(icache_sets_p)) i_icache (
      .clk_i, .reset_i, .fetch_v_i(fetch_v), .vaddr_i(mem_cmd_vaddr_i),
      .ptag_i(itlb_ptag), .ptag_v_i(itlb_hit), .uncached_i(uncached), .kill_i(kill),
      .refill_we_i(refill_we), .refill_word_i(refill_word), .refill_idx_i(refill_idx),
      .refill_done_i(refill_done || unc_done), .unc_we_i(unc_we), .unc_data_i(unc_data),
      .ready_o(icache_ready), .data_v_o(icache_data_v), .data_o(mem_resp_data_o),
      .refill_req_o(refill_req), .uncached_req_o(uncached_req), .miss_paddr_o(miss_paddr)
   );

   fe_refill #(.icache_sets_p(icache_sets_p)) i_refill (
      .clk_i, .reset_i, .req_i(refill_req), .paddr_i(miss_paddr),
      .wb_ack_i(ack0), .wb_dat_i, .wb_adr_o(m0_adr), .wb_cyc_o(m0_cyc), .wb_stb_o(m0_stb),
      .we_o(refill_we), .word_o(refill_word), .idx_o(refill_idx), .done_o(refill_done)
   );

   fe_uncached i_uncached (
      .clk_i, .reset_i, .req_i(uncached_req), .paddr_i(miss_paddr),
      .wb_ack_i(ack1), .wb_dat_i, .wb_adr_o(m1_adr), .wb_cyc_o(m1_cyc), .wb_stb_o(m1_stb),
      .we_o(unc_we), .data_o(unc_data), .done_o(unc_done)
   );

   fe_wb_arbiter i_wb_arbiter (
      .clk_i, .reset_i,
      .m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb), .m0_adr_i(m0_adr),
      .m1_cyc_i(m1_cyc), .m1_stb_i(m1_stb), .m1_adr_i(m1_adr),
      .wb_ack_i, .wb_cyc_o, .wb_stb_o, .wb_adr_o, .ack0_o(ack0), .ack1_o(ack1)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // response pipeline
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r      <= 1'b0;
         fetch_v_rr     <= 1'b0;
         itlb_miss_r    <= 1'b0;
         page_fault_r   <= 1'b0;
         access_fault_r <= 1'b0;
      end else begin
         fetch_v_r      <= fetch_v;
         fetch_v_rr     <= fetch_v_r && !mem_poison_i;
         itlb_miss_r    <= itlb_miss && !mem_poison_i;
         page_fault_r   <= page_fault && !mem_poison_i;
         access_fault_r <= access_fault && !mem_poison_i;
      end
   end

   assign mem_resp_v_o            = fetch_v_rr;
   assign mem_resp_itlb_miss_o    = itlb_miss_r;
   assign mem_resp_page_fault_o   = page_fault_r;
   assign mem_resp_access_fault_o = access_fault_r;
   assign mem_resp_icache_miss_o  = fetch_v_rr && !icache_data_v;

endmodule

// ==== tb_wb_mem.sv ====
`timescale 1ns/1ns

module tb_wb_mem
   import fe_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic [vaddr_width_c-1:0] wb_adr_i,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   output logic                     wb_ack_o,
   output logic [instr_width_c-1:0] wb_dat_o
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read-only memory model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // every word reads back as the inverse of its own byte address
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
      end else begin
         // ack comes one cycle after stb and drops as soon as it was seen
         wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
         wb_dat_o <= ~wb_adr_i;
      end
   end

endmodule

// ==== tb_fe_mem.sv ====
`timescale 1ns/1ns

module tb_fe_mem
   import fe_pkg::*;
();

   localparam int timeout_c = 100;

   logic                     clk;
   logic                     reset;
   logic                     mem_cmd_v;
   fe_op_e                   mem_cmd_op;
   logic [vaddr_width_c-1:0] mem_cmd_vaddr;
   logic [ptag_width_c-1:0]  mem_cmd_ptag;
   logic                     mem_cmd_u;
   logic                     mem_cmd_x;
   priv_e                    mem_priv;
   logic                     translation_en;
   logic                     poison;
   logic                     uncached_mode;
   logic                     wb_ack;
   logic [instr_width_c-1:0] wb_dat;
   logic                     mem_cmd_yumi;
   logic                     mem_resp_v;
   logic [instr_width_c-1:0] mem_resp_data;
   logic                     resp_itlb_miss;
   logic                     resp_page_fault;
   logic                     resp_access_fault;
   logic                     resp_icache_miss;
   logic [vaddr_width_c-1:0] wb_adr;
   logic                     wb_cyc;
   logic                     wb_stb;

   // last response seen by the testbench
   logic [instr_width_c-1:0] got_data;
   logic                     got_itlb;
   logic                     got_pf;
   logic                     got_af;
   logic                     got_icm;

   int     checks;
   int     mismatches;
   int     failures;
   integer seed;

   fe_mem #(
      .itlb_els_p   (8),
      .icache_sets_p(64)
   ) i_fe_mem (
      .clk_i(clk), .reset_i(reset),
      .mem_cmd_v_i(mem_cmd_v), .mem_cmd_op_i(mem_cmd_op), .mem_cmd_vaddr_i(mem_cmd_vaddr),
      .mem_cmd_ptag_i(mem_cmd_ptag), .mem_cmd_u_i(mem_cmd_u), .mem_cmd_x_i(mem_cmd_x),
      .mem_priv_i(mem_priv), .mem_translation_en_i(translation_en), .mem_poison_i(poison),
      .uncached_mode_i(uncached_mode), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat),
      .mem_cmd_yumi_o(mem_cmd_yumi), .mem_resp_v_o(mem_resp_v),
      .mem_resp_data_o(mem_resp_data), .mem_resp_itlb_miss_o(resp_itlb_miss),
      .mem_resp_page_fault_o(resp_page_fault), .mem_resp_access_fault_o(resp_access_fault),
      .mem_resp_icache_miss_o(resp_icache_miss),
      .wb_adr_o(wb_adr), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb)
   );

   tb_wb_mem i_wb_mem (
      .clk_i(clk), .reset_i(reset), .wb_adr_i(wb_adr), .wb_cyc_i(wb_cyc),
      .wb_stb_i(wb_stb), .wb_ack_o(wb_ack), .wb_dat_o(wb_dat)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // compare tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic compare_word(input string name, input logic [instr_width_c-1:0] got,
                               input logic [instr_width_c-1:0] exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // command and response helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic set_mode(input priv_e priv, input logic trans_en, input logic unc_mode);
      @(posedge clk);
      mem_priv       <= priv;
      translation_en <= trans_en;
      uncached_mode  <= unc_mode;
   endtask

   // returns right on the edge that consumes the command
   task automatic issue_cmd(input fe_op_e op, input logic [vaddr_width_c-1:0] vaddr,
                            input logic [ptag_width_c-1:0] ptag, input logic u,
                            input logic x, output logic ok);
      int n;
      n = 0;
      @(posedge clk);
      mem_cmd_v     <= 1'b1;
      mem_cmd_op    <= op;
      mem_cmd_vaddr <= vaddr;
      mem_cmd_ptag  <= ptag;
      mem_cmd_u     <= u;
      mem_cmd_x     <= x;
      @(negedge clk);
      while (!mem_cmd_yumi && n < timeout_c) begin
         @(negedge clk);
         n++;
      end
      ok = mem_cmd_yumi;
      if (!ok) begin
         failures++;
         $display("command %s at %h was not taken within %0d cycles",
                  op.name(), vaddr, timeout_c);
      end
      @(posedge clk);
      mem_cmd_v <= 1'b0;
   endtask

   task automatic wait_resp(output logic ok);
      int n;
      n = 0;
      @(negedge clk);
      while (!mem_resp_v && n < timeout_c) begin
         @(negedge clk);
         n++;
      end
      ok = mem_resp_v;
      if (ok) begin
         got_data = mem_resp_data;
         got_itlb = resp_itlb_miss;
         got_pf   = resp_page_fault;
         got_af   = resp_access_fault;
         got_icm  = resp_icache_miss;
      end else begin
         failures++;
         $display("no response arrived within %0d cycles", timeout_c);
      end
   endtask

   task automatic fetch(input logic [vaddr_width_c-1:0] vaddr, output logic ok);
      issue_cmd(fe_op_fetch, vaddr, '0, 1'b0, 1'b0, ok);
      if (ok) begin
         wait_resp(ok);
      end
   endtask

   task automatic check_resp(input logic [vaddr_width_c-1:0] paddr, input logic exp_itlb,
                             input logic exp_pf, input logic exp_af, input logic exp_icm);
      compare_flag("mem_resp_itlb_miss_o", got_itlb, exp_itlb);
      compare_flag("mem_resp_page_fault_o", got_pf, exp_pf);
      compare_flag("mem_resp_access_fault_o", got_af, exp_af);
      compare_flag("mem_resp_icache_miss_o", got_icm, exp_icm);
      // data only means something when the cache delivered a word
      if (!exp_icm) begin
         compare_word("mem_resp_data_o", got_data, ~paddr);
      end
   endtask

   task automatic fetch_expect(input logic [vaddr_width_c-1:0] vaddr,
                               input logic [vaddr_width_c-1:0] paddr, input logic exp_itlb,
                               input logic exp_pf, input logic exp_af, input logic exp_icm);
      logic ok;
      fetch(vaddr, ok);
      if (ok) begin
         check_resp(paddr, exp_itlb, exp_pf, exp_af, exp_icm);
      end
   endtask

   // a plain miss starts a fill, so the same fetch is repeated until it hits
   task automatic fetch_until_hit(input logic [vaddr_width_c-1:0] vaddr,
                                  input logic [vaddr_width_c-1:0] paddr);
      int   tries;
      logic ok;
      logic retry;
      tries = 0;
      ok    = 1'b0;
      retry = 1'b1;
      while (retry) begin
         fetch(vaddr, ok);
         tries++;
         retry = ok && got_icm && !(got_itlb || got_pf || got_af) && (tries < 3);
      end
      if (ok) begin
         check_resp(paddr, 1'b0, 1'b0, 1'b0, 1'b0);
      end
   endtask

   task automatic tlb_fill(input logic [vaddr_width_c-1:0] vaddr,
                           input logic [ptag_width_c-1:0] ptag, input logic u, input logic x);
      logic ok;
      issue_cmd(fe_op_tlb_fill, vaddr, ptag, u, x, ok);
   endtask

   task automatic expect_quiet(input int cycles, input string what);
      logic seen;
      seen = 1'b0;
      for (int n = 0; n < cycles; n++) begin
         @(negedge clk);
         if ((mem_resp_v || wb_cyc) && !seen) begin
            seen = 1'b1;
            failures++;
            $display("a response or bus cycle appeared after %s", what);
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic test_bare_fetch();
      set_mode(priv_s, 1'b0, 1'b0);
      fetch_expect(32'h0000_1040, 32'h0000_1040, 1'b0, 1'b0, 1'b0, 1'b1);
      fetch_until_hit(32'h0000_1040, 32'h0000_1040);
      fetch_expect(32'h0000_1048, 32'h0000_1048, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic test_translation();
      set_mode(priv_s, 1'b1, 1'b0);
      fetch_expect(32'h0004_5230, '0, 1'b1, 1'b0, 1'b0, 1'b1);
      tlb_fill(32'h0004_5000, 20'h00123, 1'b0, 1'b1);
      fetch_expect(32'h0004_5230, 32'h0012_3230, 1'b0, 1'b0, 1'b0, 1'b1);
      fetch_until_hit(32'h0004_5230, 32'h0012_3230);
   endtask

   task automatic page_fault_case(input priv_e priv, input logic u, input logic x,
                                  input logic [vaddr_width_c-1:0] vaddr,
                                  input logic [ptag_width_c-1:0] ptag);
      set_mode(priv, 1'b1, 1'b0);
      tlb_fill(vaddr, ptag, u, x);
      fetch_expect(vaddr, {ptag, vaddr[page_offset_width_c-1:0]}, 1'b0, 1'b1, 1'b0, 1'b1);
      expect_quiet(8, "a page fault");
   endtask

   task automatic test_page_faults();
      page_fault_case(priv_s, 1'b1, 1'b1, 32'h0010_0340, 20'h00200);
      page_fault_case(priv_u, 1'b0, 1'b1, 32'h0010_1340, 20'h00201);
      page_fault_case(priv_u, 1'b1, 1'b0, 32'h0010_2340, 20'h00202);
      page_fault_case(priv_s, 1'b0, 1'b0, 32'h0010_3340, 20'h00203);
   endtask

   task automatic test_fence();
      logic ok;
      set_mode(priv_s, 1'b1, 1'b0);
      fetch_until_hit(32'h0004_5230, 32'h0012_3230);
      issue_cmd(fe_op_tlb_fence, '0, '0, 1'b0, 1'b0, ok);
      fetch_expect(32'h0004_5230, '0, 1'b1, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic test_uncached();
      set_mode(priv_s, 1'b0, 1'b0);
      fetch_expect(32'h8000_0100, 32'h8000_0100, 1'b0, 1'b0, 1'b0, 1'b1);
      fetch_until_hit(32'h8000_0100, 32'h8000_0100);
      set_mode(priv_s, 1'b0, 1'b1);
      fetch_expect(32'h0000_7300, 32'h0000_7300, 1'b0, 1'b0, 1'b1, 1'b1);
      expect_quiet(8, "an access fault");
      // the holding register still serves the I/O word
      fetch_expect(32'h8000_0100, 32'h8000_0100, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic test_poison_and_random();
      logic                     ok;
      logic [vaddr_width_c-1:0] addr;
      set_mode(priv_s, 1'b0, 1'b0);
      issue_cmd(fe_op_fetch, 32'h0000_2a80, '0, 1'b0, 1'b0, ok);
      poison <= 1'b1;
      @(posedge clk);
      poison <= 1'b0;
      expect_quiet(6, "a poisoned fetch");
      for (int i = 0; i < 30; i++) begin
         addr      = $random(seed);
         addr[1:0] = 2'b00;
         fetch_until_hit(addr, addr);
      end
   endtask

   initial begin
      checks         = 0;
      mismatches     = 0;
      failures       = 0;
      seed           = 6628;
      reset          = 1'b1;
      mem_cmd_v      = 1'b0;
      mem_cmd_op     = fe_op_fetch;
      mem_cmd_vaddr  = '0;
      mem_cmd_ptag   = '0;
      mem_cmd_u      = 1'b0;
      mem_cmd_x      = 1'b0;
      mem_priv       = priv_s;
      translation_en = 1'b0;
      poison         = 1'b0;
      uncached_mode  = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      test_bare_fetch();
      test_translation();
      test_page_faults();
      test_fence();
      test_uncached();
      test_poison_and_random();

      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
fe_pkg.sv
fe_itlb.sv
fe_icache.sv
fe_refill.sv
fe_uncached.sv
fe_wb_arbiter.sv
fe_mem.sv
tb_wb_mem.sv
tb_fe_mem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fe_mem -f files.f -o sim_fe_mem
./obj_dir/sim_fe_mem > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
